// ==== fm_acc_macros.svh ====
/*
 * FM output accumulator widths and scaling
 * Operator, sample and ADPCM-A shift settings shared by the design
 */
`ifndef FM_ACC_MACROS_SVH
`define FM_ACC_MACROS_SVH

// Operator result width from the engine
`define FM_OP_W 14

// Accumulator output and sample width
`define FM_SND_W 16

// ADPCM-A is three bits below full scale
`define FM_ADPCM_A_SHIFT 3

// Operator slots in one sample frame
`define FM_NUM_SLOTS 24

// Set to 1'b1 to mute the ADPCM slots
`define FM_ACC_NOMIX 1'b0

`endif

// ==== fm_acc_pkg.sv ====
/*
 * FM output accumulator types
 * Slot, sample, channel config and config write payload definitions
 */
`include "fm_acc_macros.svh"

package fm_acc_pkg;

    // Signed operator result from the engine
    typedef logic signed [`FM_OP_W-1:0] op_res_t;

    // Signed output sample
    typedef logic signed [`FM_SND_W-1:0] snd_t;

    // Channel number, 3 and 7 unused
    typedef logic [2:0] ch_t;

    // Operator index
    typedef logic [1:0] op_t;

    // Connection algorithm
    typedef logic [2:0] alg_t;

    // Pan, bit 1 left and bit 0 right
    typedef logic [1:0] pan_t;

    // Current operator slot
    typedef struct packed {
        ch_t ch;
        op_t op;
    } slot_t;

    // Stereo sample pair
    typedef struct packed {
        snd_t left;
        snd_t right;
    } stereo_t;

    // Per-channel settings
    typedef struct packed {
        alg_t alg;
        pan_t pan;
    } ch_cfg_t;

    // Config write payload
    typedef struct packed {
        ch_t  ch;
        alg_t alg;
        pan_t pan;
    } cfg_wr_t;

    // Four-phase handshake states
    typedef enum logic {
        CFG_IDLE,
        CFG_ACK
    } cfg_state_e;

endpackage

// ==== fm_slot_seq.sv ====
/*
 * FM slot sequencer
 * Walks the 24 operator slots of a frame, operator outer and
 * channel inner over 0, 1, 2, 4, 5 and 6
 */
`timescale 1ns/1ps

module fm_slot_seq (
    input  logic              clk,
    input  logic              rst,
    input  logic              clk_en,
    output fm_acc_pkg::slot_t slot
);

    import fm_acc_pkg::*;

    // Slot counters
    ch_t ch_q;
    op_t op_q;

    // Next channel with the gaps skipped
    ch_t ch_next;
    logic ch_wrap;

    always_comb begin
        ch_wrap = 1'b0;
        case (ch_q)
            // Skip channel 3
            3'd2: ch_next = 3'd4;
            // Last channel of the operator pass
            3'd6: begin
                ch_next = 3'd0;
                ch_wrap = 1'b1;
            end
            // Channel 7 never reached, wraps anyway
            3'd7: begin
                ch_next = 3'd0;
                ch_wrap = 1'b1;
            end
            default: ch_next = ch_q + 3'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ch_q <= 3'd0;
            op_q <= 2'd0;
        end else if (clk_en) begin
            ch_q <= ch_next;
            // Operator steps once per channel pass, 3 wraps to 0
            if (ch_wrap) begin
                op_q <= op_q + 2'd1;
            end
        end
    end

    // Current slot to the mixer and the engine
    assign slot = '{ch: ch_q, op: op_q};

endmodule

// ==== fm_ch_cfg.sv ====
/*
 * FM channel config registers
 * Algorithm and pan per channel, written through a four-phase
 * req/ack port, read combinationally for the current slot
 */
`timescale 1ns/1ps

module fm_ch_cfg (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_req,
    input  fm_acc_pkg::cfg_wr_t cfg_wr,
    output logic                cfg_ack,
    input  fm_acc_pkg::ch_t     cur_ch,
    output fm_acc_pkg::ch_cfg_t cur_cfg
);

    import fm_acc_pkg::*;

    // Register file, one entry per channel number
    ch_cfg_t cfg_q [8];

    // Handshake FSM
    cfg_state_e state_q;
    cfg_state_e state_next;
    logic       wr_en;

    always_comb begin
        state_next = state_q;
        wr_en      = 1'b0;
        case (state_q)
            CFG_IDLE: begin
                // New request, write and acknowledge at once
                if (cfg_req) begin
                    wr_en      = 1'b1;
                    state_next = CFG_ACK;
                end
            end
            CFG_ACK: begin
                // Release ack once req is seen low
                if (!cfg_req) begin
                    state_next = CFG_IDLE;
                end
            end
            default: state_next = CFG_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= CFG_IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // Channels start with alg 0 panned to both sides
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                cfg_q[i] <= '{alg: 3'd0, pan: 2'b11};
            end
        end else if (wr_en) begin
            // Channels 3 and 7 stored but never selected
            cfg_q[cfg_wr.ch] <= '{alg: cfg_wr.alg, pan: cfg_wr.pan};
        end
    end

    // Ack high for the whole CFG_ACK state
    assign cfg_ack = (state_q == CFG_ACK);

    // Setting for the slot being processed
    assign cur_cfg = cfg_q[cur_ch];

endmodule

// ==== fm_single_acc.sv ====
/*
 * Single side frame accumulator
 * Sums enabled inputs over a frame in a widened register and loads
 * the saturated total into the output at the frame start slot
 */
`timescale 1ns/1ps

module fm_single_acc #(
    parameter int win  = 16,
    parameter int wout = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clk_en,
    input  logic signed [win-1:0]  op_result,
    input  logic                   sum_en,
    input  logic                   zero,
    output logic signed [wout-1:0] snd
);

    // Two guard bits above the output range
    localparam int AW = wout + 2;

    logic signed [AW-1:0]   acc_q;
    logic signed [AW-1:0]   acc_in;
    logic signed [wout-1:0] acc_sat;

    // Contribution of this slot, sign extended
    always_comb begin
        acc_in = op_result;
        if (!sum_en) begin
            acc_in = '0;
        end
    end

    // Clamp when guard bits disagree with the sign
    always_comb begin
        if (acc_q[AW-1:wout-1] == '0 || acc_q[AW-1:wout-1] == '1) begin
            acc_sat = acc_q[wout-1:0];
        end else if (acc_q[AW-1]) begin
            acc_sat = {1'b1, {(wout-1){1'b0}}};
        end else begin
            acc_sat = {1'b0, {(wout-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
            snd   <= '0;
        end else if (clk_en) begin
            if (zero) begin
                // Frame boundary, publish and restart with this slot
                snd   <= acc_sat;
                acc_q <= acc_in;
            end else begin
                acc_q <= acc_q + acc_in;
            end
        end
    end

endmodule

// ==== fm_acc_mix.sv ====
/*
 * YM2610 style stereo mixer
 * Selects FM or ADPCM data per slot, applies algorithm and pan
 * gating and feeds the left and right frame accumulators
 */
`timescale 1ns/1ps
`include "fm_acc_macros.svh"

module fm_acc_mix (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    input  fm_acc_pkg::slot_t   slot,
    input  fm_acc_pkg::ch_cfg_t cur_cfg,
    input  fm_acc_pkg::op_res_t op_result,
    input  fm_acc_pkg::stereo_t adpcm_a,
    input  fm_acc_pkg::stereo_t adpcm_b,
    output fm_acc_pkg::stereo_t snd,
    output logic                frame_done
);

    import fm_acc_pkg::*;

    logic zero;
    logic sum_en;
    snd_t op_ext;
    snd_t acc_in_l;
    snd_t acc_in_r;
    logic acc_en_l;
    logic acc_en_r;
    snd_t snd_l;
    snd_t snd_r;

    // Frame starts at op 0 of channel 0
    assign zero = (slot.op == 2'd0) && (slot.ch == 3'd0);

    // Carrier operators per algorithm
    always_comb begin
        case (cur_cfg.alg)
            3'd4:      sum_en = (slot.op == 2'd1) || (slot.op == 2'd3);
            3'd5,
            3'd6:      sum_en = (slot.op != 2'd0);
            3'd7:      sum_en = 1'b1;
            // Algorithms 0 to 3 output op 3 only
            default:   sum_en = (slot.op == 2'd3);
        endcase
    end

    // Sign extend the operator result to sample width
    assign op_ext = op_result;

    // Channel 2 and 6 op 0 slots carry ADPCM instead of FM
    always_comb begin
        if (slot.op == 2'd0 && slot.ch == 3'd2) begin
            // ADPCM-A raised to full scale
            acc_in_l = adpcm_a.left <<< `FM_ADPCM_A_SHIFT;
            acc_in_r = adpcm_a.right <<< `FM_ADPCM_A_SHIFT;
            acc_en_l = ~`FM_ACC_NOMIX;
            acc_en_r = ~`FM_ACC_NOMIX;
        end else if (slot.op == 2'd0 && slot.ch == 3'd6) begin
            acc_in_l = adpcm_b.left;
            acc_in_r = adpcm_b.right;
            acc_en_l = ~`FM_ACC_NOMIX;
            acc_en_r = ~`FM_ACC_NOMIX;
        end else begin
            acc_in_l = op_ext;
            acc_in_r = op_ext;
            acc_en_l = sum_en & cur_cfg.pan[1];
            acc_en_r = sum_en & cur_cfg.pan[0];
        end
    end

    fm_single_acc #(.win(`FM_SND_W), .wout(`FM_SND_W)) u_left (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .op_result (acc_in_l),
        .sum_en    (acc_en_l),
        .zero      (zero),
        .snd       (snd_l)
    );

    fm_single_acc #(.win(`FM_SND_W), .wout(`FM_SND_W)) u_right (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .op_result (acc_in_r),
        .sum_en    (acc_en_r),
        .zero      (zero),
        .snd       (snd_r)
    );

    assign snd = '{left: snd_l, right: snd_r};

    // One cycle strobe alongside the output load
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= clk_en & zero;
        end
    end

endmodule

// ==== fm_acc_top.sv ====
/*
 * FM stereo output accumulator top level
 * Slot sequencer, channel config registers and the mixer
 * with its left and right frame accumulators
 */
`timescale 1ns/1ps

module fm_acc_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    output fm_acc_pkg::slot_t   slot,
    input  fm_acc_pkg::op_res_t op_result,
    input  fm_acc_pkg::stereo_t adpcm_a,
    input  fm_acc_pkg::stereo_t adpcm_b,
    input  logic                cfg_req,
    input  fm_acc_pkg::cfg_wr_t cfg_wr,
    output logic                cfg_ack,
    output fm_acc_pkg::stereo_t snd,
    output logic                frame_done
);

    import fm_acc_pkg::*;

    // Settings of the channel in the current slot
    ch_cfg_t cur_cfg;

    fm_slot_seq u_slot_seq (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .slot   (slot)
    );

    fm_ch_cfg u_ch_cfg (
        .clk     (clk),
        .rst     (rst),
        .cfg_req (cfg_req),
        .cfg_wr  (cfg_wr),
        .cfg_ack (cfg_ack),
        .cur_ch  (slot.ch),
        .cur_cfg (cur_cfg)
    );

    fm_acc_mix u_acc_mix (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .slot       (slot),
        .cur_cfg    (cur_cfg),
        .op_result  (op_result),
        .adpcm_a    (adpcm_a),
        .adpcm_b    (adpcm_b),
        .snd        (snd),
        .frame_done (frame_done)
    );

endmodule

// ==== fm_acc_top_tb.sv ====
/*
 * Testbench for the FM stereo output accumulator
 * Table of channel configs and per-slot engine data, expected sums
 * worked out from the carrier, pan, ADPCM and saturation rules
 */
`timescale 1ns/1ps
`include "fm_acc_macros.svh"

module fm_acc_top_tb;

    import fm_acc_pkg::*;

    localparam int NUM_TESTS = 8;
    localparam int TIMEOUT   = 400;
    localparam int PAT_LEN   = 256;

    // DUT signals
    logic    clk;
    logic    rst;
    logic    clk_en;
    slot_t   slot;
    op_res_t op_result;
    stereo_t adpcm_a;
    stereo_t adpcm_b;
    logic    cfg_req;
    cfg_wr_t cfg_wr;
    logic    cfg_ack;
    stereo_t snd;
    logic    frame_done;

    // Stimulus table with one row per test
    string   tname [NUM_TESTS];
    ch_cfg_t tcfg  [NUM_TESTS][6];
    op_res_t tops  [NUM_TESTS][`FM_NUM_SLOTS];
    stereo_t tad_a [NUM_TESTS];
    stereo_t tad_b [NUM_TESTS];
    stereo_t texp  [NUM_TESTS];

    // Driver control changed on rising edges only
    int   cur_idx;
    logic run_en;
    int   en_count;
    int   count_a;
    int   count_b;

    // Pre-drawn clk_en pattern, about one gap in four
    logic en_pat [PAT_LEN];
    int   en_pos;

    // Expected slot position within the frame, 0 to 23
    int   exp_pos;

    fm_acc_top UUT (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .slot       (slot),
        .op_result  (op_result),
        .adpcm_a    (adpcm_a),
        .adpcm_b    (adpcm_b),
        .cfg_req    (cfg_req),
        .cfg_wr     (cfg_wr),
        .cfg_ack    (cfg_ack),
        .snd        (snd),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Channel number for a table position with 3 skipped
    function automatic int chan_of(input int pos);
        return (pos < 3) ? pos : pos + 1;
    endfunction

    // Table slot for the slot shown by the DUT
    function automatic int slot_index(input slot_t s);
        int pos;
        pos = (s.ch < 3'd3) ? int'(s.ch) : int'(s.ch) - 1;
        return (int'(s.op) * 6 + pos) % `FM_NUM_SLOTS;
    endfunction

    // Slot at a frame position, operator outer and channel inner
    function automatic slot_t slot_at(input int pos);
        slot_t s;
        s.op = op_t'(pos / 6);
        s.ch = ch_t'(chan_of(pos % 6));
        return s;
    endfunction

    // Operators that reach the output for each algorithm
    function automatic bit is_carrier(input alg_t alg, input int op);
        if (alg == 3'd7) begin
            return 1'b1;
        end
        if (alg >= 3'd5) begin
            return op != 0;
        end
        // Odd operators 1 and 3
        if (alg == 3'd4) begin
            return (op % 2) == 1;
        end
        return op == 3;
    endfunction

    function automatic snd_t saturate(input int v);
        if (v > (1 <<< (`FM_SND_W - 1)) - 1) begin
            return {1'b0, {(`FM_SND_W - 1){1'b1}}};
        end
        if (v < -(1 <<< (`FM_SND_W - 1))) begin
            return {1'b1, {(`FM_SND_W - 1){1'b0}}};
        end
        return snd_t'(v);
    endfunction

    function automatic stereo_t make_pair(input int l, input int r);
        stereo_t p;
        p.left  = snd_t'(l);
        p.right = snd_t'(r);
        return p;
    endfunction

    function automatic stereo_t expected_sum(input int idx);
        int      left;
        int      right;
        int      op;
        int      ch;
        ch_cfg_t cfg;
        stereo_t res;
        left  = 0;
        right = 0;
        for (int k = 0; k < `FM_NUM_SLOTS; k++) begin
            op  = k / 6;
            ch  = chan_of(k % 6);
            cfg = tcfg[idx][k % 6];
            if (op == 0 && ch == 2) begin
                // ADPCM-A scaled up on both sides
                if (!(`FM_ACC_NOMIX)) begin
                    left  += int'(tad_a[idx].left) * (1 << `FM_ADPCM_A_SHIFT);
                    right += int'(tad_a[idx].right) * (1 << `FM_ADPCM_A_SHIFT);
                end
            end else if (op == 0 && ch == 6) begin
                if (!(`FM_ACC_NOMIX)) begin
                    left  += int'(tad_b[idx].left);
                    right += int'(tad_b[idx].right);
                end
            end else if (is_carrier(cfg.alg, op)) begin
                if (cfg.pan[1]) begin
                    left += int'(tops[idx][k]);
                end
                if (cfg.pan[0]) begin
                    right += int'(tops[idx][k]);
                end
            end
        end
        res.left  = saturate(left);
        res.right = saturate(right);
        return res;
    endfunction

    // Algs as six octal digits and pans as six bit pairs from channel 0
    task automatic set_test(input int idx, input string name, input logic [17:0] algs,
                            input logic [11:0] pans, input int base, input int step,
                            input stereo_t ad_a, input stereo_t ad_b);
        tname[idx] = name;
        for (int p = 0; p < 6; p++) begin
            tcfg[idx][p].alg = algs[(5 - p) * 3 +: 3];
            tcfg[idx][p].pan = pans[(5 - p) * 2 +: 2];
        end
        for (int k = 0; k < `FM_NUM_SLOTS; k++) begin
            tops[idx][k] = op_res_t'(base + k * step);
        end
        tad_a[idx] = ad_a;
        tad_b[idx] = ad_b;
        texp[idx]  = expected_sum(idx);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_stereo(input string name, input stereo_t exp, input stereo_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected L=%0d R=%0d, actual L=%0d R=%0d",
                                name, exp.left, exp.right, act.left, act.right));
        end
    endtask

    task automatic compare_slot(input string name, input slot_t exp, input slot_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected op=%0d ch=%0d, actual op=%0d ch=%0d",
                                name, exp.op, exp.ch, act.op, act.ch));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // Four-phase write where ack rises and then falls behind req
    task automatic write_cfg(input ch_t ch, input ch_cfg_t cfg);
        int waited;
        @(negedge clk);
        if (cfg_ack) begin
            abort_run($sformatf("cfg_ack was still high before the write to channel %0d", ch));
        end
        cfg_wr  = '{ch: ch, alg: cfg.alg, pan: cfg.pan};
        cfg_req = 1'b1;
        waited  = 0;
        while (!cfg_ack) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("cfg_ack never rose for the write to channel %0d", ch));
            end
        end
        cfg_req = 1'b0;
        waited  = 0;
        while (cfg_ack) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("cfg_ack stayed high after req dropped, channel %0d", ch));
            end
        end
    endtask

    // Returns the clk_en count seen at the frame_done pulse
    task automatic wait_frame(input string what, output int count);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!frame_done) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("frame_done never came during %s", what));
            end
        end
        count = en_count;
    endtask

    // Engine model supplying data for the slot on show
    always @(negedge clk) begin
        compare_slot("slot_order", slot_at(exp_pos), slot);
        clk_en    = run_en && en_pat[en_pos];
        en_pos    = (en_pos + 1) % PAT_LEN;
        op_result = tops[cur_idx][slot_index(slot)];
        adpcm_a   = tad_a[cur_idx];
        adpcm_b   = tad_b[cur_idx];
    end

    always @(posedge clk) begin
        if (rst) begin
            en_count <= 0;
            exp_pos  <= 0;
        end else if (clk_en) begin
            en_count <= en_count + 1;
            exp_pos  <= (exp_pos + 1) % `FM_NUM_SLOTS;
        end
    end

    initial begin
        void'($urandom(32'h55a4f007));
        rst       = 1'b1;
        clk_en    = 1'b0;
        op_result = '0;
        adpcm_a   = '0;
        adpcm_b   = '0;
        cfg_req   = 1'b0;
        cfg_wr    = '0;
        run_en    = 1'b0;
        cur_idx   = 0;
        en_pos    = 0;

        for (int i = 0; i < PAT_LEN; i++) begin
            en_pat[i] = (($urandom % 4) != 0);
        end

        set_test(0, "alg0_to_3", 18'o012301, 12'hfff, 10, 3, make_pair(0, 0), make_pair(0, 0));
        set_test(1, "alg4_to_7", 18'o456747, 12'hfff, -40, 7, make_pair(0, 0), make_pair(0, 0));
        set_test(2, "pan_sides", 18'o777777, 12'b10_01_11_00_10_01, 25, -2,
                 make_pair(0, 0), make_pair(0, 0));
        set_test(3, "adpcm_only", 18'o000000, 12'h000, 500, 1,
                 make_pair(100, -50), make_pair(-300, 700));
        set_test(4, "adpcm_with_fm", 18'o070707, 12'hfff, -100, 11,
                 make_pair(-20, 40), make_pair(1234, -4321));
        set_test(5, "sat_positive", 18'o777777, 12'hfff, 4000, 0,
                 make_pair(1000, 1000), make_pair(8000, 8000));
        set_test(6, "sat_negative", 18'o777777, 12'hfff, -4000, 0,
                 make_pair(-1000, -1000), make_pair(-8000, -8000));
        // Random configs and data with sums inside the guard bits
        set_test(7, "random_mix", 18'($urandom), 12'($urandom),
                 int'($urandom % 601) - 300, int'($urandom % 21) - 10,
                 make_pair(int'($urandom % 2001) - 1000, int'($urandom % 2001) - 1000),
                 make_pair(int'($urandom % 2001) - 1000, int'($urandom % 2001) - 1000));

        repeat (3) @(negedge clk);
        rst = 1'b0;
        compare_bit("reset_cfg_ack", 1'b0, cfg_ack);
        compare_bit("reset_frame_done", 1'b0, frame_done);

        // First frame after reset has nothing enabled
        @(posedge clk);
        run_en = 1'b1;
        wait_frame("the first frame", count_a);
        compare_stereo("reset_frame", '0, snd);

        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            run_en  = 1'b0;
            cur_idx = t;
            for (int p = 0; p < 6; p++) begin
                write_cfg(ch_t'(chan_of(p)), tcfg[t][p]);
            end
            @(posedge clk);
            run_en = 1'b1;
            // Warm-up frame flushes the partial frame
            wait_frame({tname[t], " warm-up"}, count_a);
            wait_frame(tname[t], count_b);
            compare_count({tname[t], " frame length"}, `FM_NUM_SLOTS, count_b - count_a);
            compare_stereo(tname[t], texp[t], snd);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== fm_acc_top.f ====
+incdir+.
fm_acc_pkg.sv
fm_slot_seq.sv
fm_ch_cfg.sv
fm_single_acc.sv
fm_acc_mix.sv
fm_acc_top.sv
fm_acc_top_tb.sv

// ==== Bender.yml ====
package:
  name: fm_acc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fm_acc_pkg.sv
      - fm_slot_seq.sv
      - fm_ch_cfg.sv
      - fm_single_acc.sv
      - fm_acc_mix.sv
      - fm_acc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fm_acc_top_tb.sv
